/* Bender.yml */
package:
  name: audio_out

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/audio_pkg.sv
      - design/cen_divider.sv
      - interpol/cic_interpolator.sv
      - dac/sigma_delta_dac.sv
      - design/audio_out_top.sv

  - target: simulation
    include_dirs:
      - common
    files:
      - sim/audio_out_tb.sv

/* common/audio_pkg.sv */
// shared audio word types; every width comes from the settings header, so rebuild after editing it.
`include "audio_settings.svh"

package audio_pkg;

    // one audio sample, two's complement, used at every channel port.
    typedef logic signed [`AUDIO_INW-1:0] sample_t;

    // comb, zero-stuff and integrator value inside the interpolator.
    typedef logic signed [`AUDIO_CALCW-1:0] acc_t;

    // position inside one interpolation period.
    typedef logic [`AUDIO_CNTW-1:0] phase_t;

    // error integrator of the sigma-delta modulator.
    typedef logic signed [`AUDIO_DAC_W-1:0] dac_acc_t;

endpackage

/* common/audio_settings.svh */
// compile-time audio path settings; nothing here can be changed at run time, and CALCW must cover the rate gain.
`ifndef AUDIO_SETTINGS_SVH
`define AUDIO_SETTINGS_SVH

// width of one audio sample at the synthesizer and at the output.
`define AUDIO_INW 16

// internal CIC word. It is the sample width plus two guard bits.
// Two bits are enough for a rate of 4 with two stages, because the
// stage gain is rate^(stages-1) = 4.
`define AUDIO_CALCW 18

// interpolation factor between synthesizer rate and output rate.
`define AUDIO_RATE 4

// width of the phase counter inside one interpolation period.
`define AUDIO_CNTW 4

// system clocks per output-rate enable.
// One synthesizer sample lasts RATE * OUT_DIV = 24 clocks.
`define AUDIO_OUT_DIV 6

// width of the sigma-delta error integrators.
`define AUDIO_DAC_W 20

`endif

/* dac/sigma_delta_dac.sv */
// runs on every clock; inputs beyond +-7/8 full scale are clipped, so the density rule holds inside that range.
`timescale 1ns/10ps
`include "audio_settings.svh"

module sigma_delta_dac import audio_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  sample_t snd,
    output logic    dac_bit
);

    // feedback is plus or minus full scale of the sample word.
    localparam int FS = 2 ** (`AUDIO_INW - 1);

    // a second-order loop overloads as the input nears full scale.
    // Holding the input 1/8 below full scale keeps both integrators well
    // inside the DAC_W range.
    localparam sample_t CLIP_HI = sample_t'(FS - FS / 8);
    localparam sample_t CLIP_LO = sample_t'(-(FS - FS / 8));

    localparam dac_acc_t ACC_MAX = {1'b0, {(`AUDIO_DAC_W - 1){1'b1}}};
    localparam dac_acc_t ACC_MIN = {1'b1, {(`AUDIO_DAC_W - 1){1'b0}}};

    sample_t  snd_lim;
    dac_acc_t x_ext;
    dac_acc_t fb;
    dac_acc_t integ1;
    dac_acc_t integ2;
    dac_acc_t integ1_next;
    dac_acc_t integ2_next;

    always_comb begin
        if (snd > CLIP_HI) begin
            snd_lim = CLIP_HI;
        end else if (snd < CLIP_LO) begin
            snd_lim = CLIP_LO;
        end else begin
            snd_lim = snd;
        end
    end

    assign x_ext = dac_acc_t'(snd_lim);

    // a one on the pin stands for +FS, a zero for -FS.
    // The mean of the feedback equals the input, which gives a one-density
    // of (snd + FS) / 2^INW, the offset-binary value.
    assign fb = dac_bit ? dac_acc_t'(FS) : -dac_acc_t'(FS);

    // the second integrator takes the new value of the first.
    // This gives the noise transfer (1 - z^-1)^2.
    assign integ1_next = integ1 + x_ext - fb;
    assign integ2_next = integ2 + integ1_next - fb;

    // the output bit is the quantized sign of integrator 2.
    // It is registered together with the integrators, so it always matches
    // the integrator state that produced it.
    always_ff @(posedge clk) begin
        if (rst) begin
            integ1  <= '0;
            integ2  <= '0;
            dac_bit <= 1'b0;
        end else begin
            integ1  <= integ1_next;
            integ2  <= integ2_next;
            dac_bit <= ~integ2_next[`AUDIO_DAC_W-1];
        end
    end

    // an integrator at its limit means the loop has gone unstable.
    a_integ1_bounded: assert property (
        @(posedge clk) disable iff (rst) (integ1 != ACC_MAX) && (integ1 != ACC_MIN)
    );

    a_integ2_bounded: assert property (
        @(posedge clk) disable iff (rst) (integ2 != ACC_MAX) && (integ2 != ACC_MIN)
    );

endmodule

/* design/audio_out_top.sv */
// no back-pressure; the source must present a new stereo sample on every sample_req or it is lost.
`timescale 1ns/10ps

module audio_out_top import audio_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  sample_t snd_left,
    input  sample_t snd_right,
    output logic    sample_req,
    output logic    sample_valid,
    output sample_t out_left,
    output sample_t out_right,
    output logic    dac_left,
    output logic    dac_right
);

    logic cen_in;
    logic cen_out;

    // one divider feeds both channels, so the two interpolators stay in phase.
    cen_divider cen_divider_inst (
        .clk     (clk),
        .rst     (rst),
        .cen_in  (cen_in),
        .cen_out (cen_out)
    );

    // the source samples its next value on the synthesizer strobe.
    assign sample_req = cen_in;

    // the interpolated outputs change on the output strobe.
    assign sample_valid = cen_out;

    cic_interpolator cic_left_inst (
        .clk     (clk),
        .rst     (rst),
        .cen_in  (cen_in),
        .cen_out (cen_out),
        .snd_in  (snd_left),
        .snd_out (out_left)
    );

    cic_interpolator cic_right_inst (
        .clk     (clk),
        .rst     (rst),
        .cen_in  (cen_in),
        .cen_out (cen_out),
        .snd_in  (snd_right),
        .snd_out (out_right)
    );

    // each modulator sees its interpolated sample held between strobes.
    sigma_delta_dac dac_left_inst (
        .clk     (clk),
        .rst     (rst),
        .snd     (out_left),
        .dac_bit (dac_left)
    );

    sigma_delta_dac dac_right_inst (
        .clk     (clk),
        .rst     (rst),
        .snd     (out_right),
        .dac_bit (dac_right)
    );

endmodule

/* design/cen_divider.sv */
// strobes are one clock wide and combinational from the counters; first cen_out is OUT_DIV clocks after reset.
`timescale 1ns/10ps
`include "audio_settings.svh"

module cen_divider import audio_pkg::*; (
    input  logic clk,
    input  logic rst,
    output logic cen_in,
    output logic cen_out
);

    localparam int DIV_W = $clog2(`AUDIO_OUT_DIV);

    logic [DIV_W-1:0] clk_cnt;
    phase_t           phase;

    // the clock counter wraps every OUT_DIV clocks.
    // Reset leaves it at zero, so the first wrap comes OUT_DIV clocks
    // after rst is released.
    always_ff @(posedge clk) begin
        if (rst) begin
            clk_cnt <= '0;
        end else if (clk_cnt == DIV_W'(`AUDIO_OUT_DIV - 1)) begin
            clk_cnt <= '0;
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

    // the output-rate enable is the last count of each division period.
    assign cen_out = (clk_cnt == DIV_W'(`AUDIO_OUT_DIV - 1));

    // the phase steps once per output sample and wraps at RATE.
    // The interpolators keep an identical counter of their own.
    always_ff @(posedge clk) begin
        if (rst) begin
            phase <= '0;
        end else if (cen_out) begin
            if (phase == phase_t'(`AUDIO_RATE - 1)) begin
                phase <= '0;
            end else begin
                phase <= phase + 1'b1;
            end
        end
    end

    // a new synthesizer sample is taken on the output strobe at phase zero.
    // The very first cen_out after reset is therefore also a cen_in.
    assign cen_in = cen_out && (phase == '0);

    // the synthesizer strobe must always ride on an output strobe.
    a_cen_in_on_out: assert property (
        @(posedge clk) disable iff (rst) cen_in |-> cen_out
    );

    // once seen, cen_in stays low for one full synthesizer period minus one clock.
    a_cen_in_period: assert property (
        @(posedge clk) disable iff (rst)
        cen_in |=> !cen_in [* (`AUDIO_RATE * `AUDIO_OUT_DIV - 1)]
    );

endmodule

/* filelist.f */
+incdir+common
common/audio_pkg.sv
design/cen_divider.sv
interpol/cic_interpolator.sv
dac/sigma_delta_dac.sv
design/audio_out_top.sv
sim/audio_out_tb.sv

/* interpol/cic_interpolator.sv */
// unity DC gain only for RATE 4 with two guard bits; cen_in must come at phase zero of the shared divider.
`timescale 1ns/10ps
`include "audio_settings.svh"

module cic_interpolator import audio_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    cen_in,
    input  logic    cen_out,
    input  sample_t snd_in,
    output sample_t snd_out
);

    sample_t last;
    acc_t    comb1;
    acc_t    comb2;
    acc_t    last_comb1;
    acc_t    stuffed;
    acc_t    integ1;
    acc_t    integ2;
    phase_t  phase;

    // integ2 + integ1 with one extra bit, so a wrap of integrator 2 shows up
    // as a disagreement between the two top bits.
    logic [`AUDIO_CALCW:0] integ2_sum;

    // the two comb stages run at the synthesizer rate.
    // Casting a signed sample to acc_t sign-extends it into the guard bits.
    always_ff @(posedge clk) begin
        if (rst) begin
            last       <= '0;
            comb1      <= '0;
            last_comb1 <= '0;
            comb2      <= '0;
        end else if (cen_in) begin
            last       <= snd_in;
            comb1      <= acc_t'(snd_in) - acc_t'(last);
            last_comb1 <= comb1;
            comb2      <= comb1 - last_comb1;
        end
    end

    // zero stuffing at the output rate.
    // Only the first output slot of each period carries the comb result,
    // the other RATE-1 slots are zero.
    always_ff @(posedge clk) begin
        if (rst) begin
            stuffed <= '0;
            phase   <= '0;
        end else if (cen_out) begin
            stuffed <= (phase == '0) ? comb2 : '0;
            if (phase == phase_t'(`AUDIO_RATE - 1)) begin
                phase <= '0;
            end else begin
                phase <= phase + 1'b1;
            end
        end
    end

    // two integrators at the output rate.
    // The stage gain is RATE, so dropping the WDIFF low bits of integrator 2
    // brings the DC gain back to one.
    always_ff @(posedge clk) begin
        if (rst) begin
            integ1  <= '0;
            integ2  <= '0;
            snd_out <= '0;
        end else if (cen_out) begin
            integ1  <= integ1 + stuffed;
            integ2  <= integ2 + integ1;
            snd_out <= integ2[`AUDIO_CALCW-1 -: `AUDIO_INW];
        end
    end

    assign integ2_sum = {integ2[`AUDIO_CALCW-1], integ2} + {integ1[`AUDIO_CALCW-1], integ1};

    // the local phase must stay in step with the divider phase.
    a_phase_aligned: assert property (
        @(posedge clk) disable iff (rst) cen_in |-> (phase == '0)
    );

    // integrator 2 never wraps, so the bits kept for snd_out are valid.
    a_no_wrap: assert property (
        @(posedge clk) disable iff (rst)
        cen_out |-> (integ2_sum[`AUDIO_CALCW] == integ2_sum[`AUDIO_CALCW-1])
    );

endmodule

/* sim/audio_out_tb.sv */
// checks strobes, CIC output against a behavioral model and DAC density; stops at the first error.
`timescale 1ns/10ps
`include "audio_settings.svh"

module audio_out_tb import audio_pkg::*; ();

    localparam int PERIOD_NS   = 40;
    localparam int SAMPLE_CLKS = `AUDIO_RATE * `AUDIO_OUT_DIV;
    localparam int DAC_WINDOW  = 4096;
    localparam int DAC_TOL     = 8;
    localparam int SHIFT       = `AUDIO_CALCW - `AUDIO_INW;
    localparam int ACC_HI      = 2 ** (`AUDIO_CALCW - 1) - 1;
    localparam int ACC_LO      = -(2 ** (`AUDIO_CALCW - 1));

    // what is checked once an entry has been presented for its repeat count.
    localparam int MODE_TRACK   = 0;
    localparam int MODE_SETTLED = 1;
    localparam int MODE_DENSITY = 2;

    localparam sample_t FS_POS = sample_t'(32767);
    localparam sample_t FS_NEG = sample_t'(-32768);

    logic    clk;
    logic    rst;
    sample_t snd_left;
    sample_t snd_right;
    logic    sample_req;
    logic    sample_valid;
    sample_t out_left;
    sample_t out_right;
    logic    dac_left;
    logic    dac_right;

    // stimulus table, one column per queue.
    sample_t tbl_left[$];
    sample_t tbl_right[$];
    int      tbl_reps[$];
    int      tbl_mode[$];

    integer seed;
    longint limit_ns = 0;
    int     cyc = 0;
    bit     got_req;
    bit     counting = 0;
    int     win_clks;
    int     ones_l;
    int     ones_r;

    // behavioral CIC state, index 0 is left and 1 is right.
    sample_t m_last[2]       = '{default: '0};
    acc_t    m_comb1[2]      = '{default: '0};
    acc_t    m_last_comb1[2] = '{default: '0};
    acc_t    m_comb2[2]      = '{default: '0};
    acc_t    m_stuffed[2]    = '{default: '0};
    acc_t    m_integ1[2]     = '{default: '0};
    acc_t    m_integ2[2]     = '{default: '0};
    sample_t m_out[2]        = '{default: '0};
    int      m_phase         = 0;

    audio_out_top audio_out_top_inst (
        .clk          (clk),
        .rst          (rst),
        .snd_left     (snd_left),
        .snd_right    (snd_right),
        .sample_req   (sample_req),
        .sample_valid (sample_valid),
        .out_left     (out_left),
        .out_right    (out_right),
        .dac_left     (dac_left),
        .dac_right    (dac_right)
    );

    initial clk = 1'b0;
    always #(PERIOD_NS / 2) clk = ~clk;

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_sample(input sample_t got, input sample_t exp, input string what);
        if (got !== exp) begin
            report_failure($sformatf("Mismatch at %0t: %s got %0d expected %0d",
                                     $time, what, got, exp));
        end
    endtask

    task automatic check_strobe(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            report_failure($sformatf("Mismatch at %0t: %s got %b expected %b",
                                     $time, what, got, exp));
        end
    endtask

    task automatic check_density(input int ones, input int expected, input int tol,
                                 input string what);
        if (ones < expected - tol || ones > expected + tol) begin
            report_failure($sformatf("Mismatch at %0t: %s counted %0d ones, expected %0d +- %0d",
                                     $time, what, ones, expected, tol));
        end
    endtask

    // k is the number of clock edges seen since rst was released.
    // The output strobe sits on the last clock of every division period.
    function automatic logic valid_expected(input int k);
        return (k % `AUDIO_OUT_DIV) == (`AUDIO_OUT_DIV - 1);
    endfunction

    // every RATE-th output strobe, starting with the first one, is a request.
    function automatic logic req_expected(input int k);
        return valid_expected(k) && (((k / `AUDIO_OUT_DIV) % `AUDIO_RATE) == 0);
    endfunction

    // offset-binary density, the fraction of ones times the window length.
    function automatic int density_expected(input sample_t v);
        return ((int'(v) + 2 ** (`AUDIO_INW - 1)) * DAC_WINDOW) / (2 ** `AUDIO_INW);
    endfunction

    // one clock of the CIC model, all new values taken from the old state.
    // Within a channel the output-rate stages go first, so they still see
    // the comb values from before this edge.
    task automatic update_model(input logic req, input logic vld,
                                input sample_t in_l, input sample_t in_r);
        sample_t x[2];
        int      sum2;
        int      c1;
        acc_t    c2;
        x[0] = in_l;
        x[1] = in_r;
        for (int ch = 0; ch < 2; ch++) begin
            if (vld) begin
                sum2 = int'(m_integ2[ch]) + int'(m_integ1[ch]);
                if (sum2 > ACC_HI || sum2 < ACC_LO) begin
                    report_failure($sformatf("model integrator 2 left its range on channel %0d",
                                             ch));
                end
                m_out[ch]     = sample_t'(m_integ2[ch] >>> SHIFT);
                m_integ2[ch]  = acc_t'(sum2);
                m_integ1[ch]  = m_integ1[ch] + m_stuffed[ch];
                m_stuffed[ch] = (m_phase == 0) ? m_comb2[ch] : acc_t'(0);
            end
            if (req) begin
                c1               = int'(x[ch]) - int'(m_last[ch]);
                c2               = m_comb1[ch] - m_last_comb1[ch];
                m_last_comb1[ch] = m_comb1[ch];
                m_comb1[ch]      = acc_t'(c1);
                m_comb2[ch]      = c2;
                m_last[ch]       = x[ch];
            end
        end
        if (vld) begin
            m_phase = (m_phase + 1) % `AUDIO_RATE;
        end
    endtask

    // strobes and inputs are sampled at the falling edge, where they are stable.
    // Outputs are compared 2 ns after the rising edge that updated them.
    task automatic step_clock();
        logic    req;
        logic    vld;
        sample_t in_l;
        sample_t in_r;
        @(negedge clk);
        req  = sample_req;
        vld  = sample_valid;
        in_l = snd_left;
        in_r = snd_right;
        check_strobe(vld, valid_expected(cyc), "sample_valid");
        check_strobe(req, req_expected(cyc), "sample_req");
        if (counting && win_clks < DAC_WINDOW) begin
            ones_l   = ones_l + int'(dac_left);
            ones_r   = ones_r + int'(dac_right);
            win_clks = win_clks + 1;
        end
        @(posedge clk);
        update_model(req, vld, in_l, in_r);
        cyc     = cyc + 1;
        got_req = req;
        #2;
        if (vld) begin
            check_sample(out_left, m_out[0], "out_left against model");
            check_sample(out_right, m_out[1], "out_right against model");
        end
    endtask

    // the value stays on the inputs until the edge that raises sample_req.
    task automatic present_sample(input sample_t l, input sample_t r);
        int waited;
        snd_left  = l;
        snd_right = r;
        waited    = 0;
        got_req   = 1'b0;
        while (!got_req) begin
            step_clock();
            waited = waited + 1;
            if (!got_req && waited > SAMPLE_CLKS) begin
                report_failure("sample_req did not arrive within one synthesizer period");
            end
        end
    endtask

    // keeps feeding the same DC value while both DAC bits are counted.
    task automatic run_density(input sample_t l, input sample_t r);
        counting = 1'b1;
        win_clks = 0;
        ones_l   = 0;
        ones_r   = 0;
        while (win_clks < DAC_WINDOW) begin
            present_sample(l, r);
        end
        counting = 1'b0;
        check_density(ones_l, density_expected(l), DAC_TOL, "dac_left density");
        check_density(ones_r, density_expected(r), DAC_TOL, "dac_right density");
    endtask

    task automatic add_entry(input sample_t l, input sample_t r, input int reps, input int mode);
        tbl_left.push_back(l);
        tbl_right.push_back(r);
        tbl_reps.push_back(reps);
        tbl_mode.push_back(mode);
    endtask

    task automatic build_table();
        integer v;
        // held constants, with the two channels at different values.
        add_entry(sample_t'(0), sample_t'(0), 8, MODE_SETTLED);
        add_entry(FS_POS, FS_NEG, 8, MODE_SETTLED);
        add_entry(FS_NEG, FS_POS, 8, MODE_SETTLED);
        add_entry(sample_t'(0), FS_POS, 8, MODE_SETTLED);
        add_entry(FS_NEG, sample_t'(0), 8, MODE_SETTLED);
        // full-scale step from the most negative to the most positive value.
        add_entry(FS_NEG, FS_NEG, 8, MODE_SETTLED);
        add_entry(FS_POS, FS_POS, 8, MODE_SETTLED);
        // short steps land on every zero-stuff phase of the next period.
        add_entry(sample_t'(1000), sample_t'(-1000), 3, MODE_TRACK);
        add_entry(sample_t'(-20000), sample_t'(25000), 2, MODE_TRACK);
        add_entry(sample_t'(12345), sample_t'(-321), 1, MODE_TRACK);
        for (int i = 0; i < 24; i++) begin
            add_entry(sample_t'(-30000 + i * 2500), sample_t'(30000 - i * 2600), 1, MODE_TRACK);
        end
        // random segment, the upper half of each draw feeds the right channel.
        for (int i = 0; i < 40; i++) begin
            v = $random(seed);
            add_entry(sample_t'(v), sample_t'(v >>> 16), 1 + (i % 3), MODE_TRACK);
        end
        add_entry(sample_t'(-16384), sample_t'(16384), 8, MODE_DENSITY);
        add_entry(sample_t'(0), sample_t'(0), 8, MODE_DENSITY);
        add_entry(sample_t'(16384), sample_t'(-16384), 8, MODE_DENSITY);
    endtask

    // twice the nominal run length, with one spare period per DAC window.
    function automatic longint timeout_ns();
        longint clks;
        clks = 5;
        for (int e = 0; e < tbl_reps.size(); e++) begin
            clks = clks + longint'(tbl_reps[e]) * SAMPLE_CLKS;
            if (tbl_mode[e] == MODE_DENSITY) begin
                clks = clks + DAC_WINDOW + SAMPLE_CLKS;
            end
        end
        return 2 * clks * PERIOD_NS;
    endfunction

    initial begin
        wait (limit_ns > 0);
        #(limit_ns);
        report_failure("the run timed out before all table entries were applied");
    end

    initial begin
        rst       = 1'b1;
        snd_left  = '0;
        snd_right = '0;
        seed      = 22544;
        build_table();
        limit_ns = timeout_ns();
        // during reset the strobes, outputs and DAC bits must all be low.
        repeat (5) begin
            @(posedge clk);
            #2;
            check_strobe(sample_req, 1'b0, "sample_req in reset");
            check_strobe(sample_valid, 1'b0, "sample_valid in reset");
            check_sample(out_left, sample_t'(0), "out_left in reset");
            check_sample(out_right, sample_t'(0), "out_right in reset");
            check_strobe(dac_left, 1'b0, "dac_left in reset");
            check_strobe(dac_right, 1'b0, "dac_right in reset");
        end
        rst = 1'b0;
        for (int e = 0; e < tbl_left.size(); e++) begin
            repeat (tbl_reps[e]) begin
                present_sample(tbl_left[e], tbl_right[e]);
            end
            if (tbl_mode[e] == MODE_SETTLED) begin
                check_sample(out_left, tbl_left[e], "settled out_left");
                check_sample(out_right, tbl_right[e], "settled out_right");
            end else if (tbl_mode[e] == MODE_DENSITY) begin
                run_density(tbl_left[e], tbl_right[e]);
            end
        end
        $display(">>> PASS");
        $finish;
    end

endmodule
